// ==== rtl/helios_pkg.sv ====
package helios_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] data_t;
    typedef logic [31:0]     addr_t;
    typedef logic [31:0]     insn_t;
    typedef logic [4:0]      reg_sel_t;
    typedef logic [3:0]      alu_op_t;

    // alu operation codes
    localparam alu_op_t ALU_ADD  = 4'd0;
    localparam alu_op_t ALU_SUB  = 4'd1;
    localparam alu_op_t ALU_AND  = 4'd2;
    localparam alu_op_t ALU_OR   = 4'd3;
    localparam alu_op_t ALU_XOR  = 4'd4;
    localparam alu_op_t ALU_SLL  = 4'd5;
    localparam alu_op_t ALU_SRL  = 4'd6;
    localparam alu_op_t ALU_SRA  = 4'd7;
    localparam alu_op_t ALU_SLT  = 4'd8;
    localparam alu_op_t ALU_SLTU = 4'd9;
    localparam alu_op_t ALU_LUI  = 4'd10;

endpackage

// ==== rtl/core_ifs.sv ====
`timescale 1ns/1ps

interface dispatch_if;
    logic                 valid;
    helios_pkg::reg_sel_t rd;
    logic                 wr_reg;
    helios_pkg::reg_sel_t rs1;
    helios_pkg::reg_sel_t rs2;
    logic                 uses_rs1;
    logic                 uses_rs2;
    logic                 use_imm;
    helios_pkg::data_t    imm;
    helios_pkg::alu_op_t  alu_op;

    modport src (output valid, rd, wr_reg, rs1, rs2, uses_rs1, uses_rs2, use_imm, imm, alu_op);
    modport dst (input valid, rd, wr_reg, rs1, rs2, uses_rs1, uses_rs2, use_imm, imm, alu_op);
endinterface

interface issue_if #(
    parameter int RRF_NUM = 8
);
    logic                       valid;
    helios_pkg::alu_op_t        alu_op;
    helios_pkg::data_t          op_a;
    helios_pkg::data_t          op_b;
    logic [$clog2(RRF_NUM)-1:0] tag;

    modport src (output valid, alu_op, op_a, op_b, tag);
    modport dst (input valid, alu_op, op_a, op_b, tag);
endinterface

// ==== rtl/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit (
    input  logic              clk_i,
    input  logic              rst_i,
    input  helios_pkg::insn_t idata_i,
    input  logic              stall_i,
    output helios_pkg::addr_t iaddr_o,
    output helios_pkg::insn_t insn_o,
    output logic              insn_valid_o
);

    helios_pkg::addr_t pc_q;

    assign iaddr_o = pc_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pc_q         <= '0;
            insn_valid_o <= 1'b0;
        end else if (!stall_i) begin
            pc_q         <= pc_q + 32'd4;
            insn_valid_o <= 1'b1;
        end
    end

    // word for the address presented this cycle
    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            insn_o <= idata_i;
        end
    end

endmodule

// ==== rtl/decode_unit.sv ====
`timescale 1ns/1ps

module decode_unit (
    input  logic              clk_i,
    input  logic              rst_i,
    input  helios_pkg::insn_t insn_i,
    input  logic              insn_valid_i,
    input  logic              stall_i,
    dispatch_if.src           dp_o
);

    logic [6:0]          opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    helios_pkg::alu_op_t op_d;
    helios_pkg::data_t   imm_d;
    logic                legal_d;
    logic                uses_rs1_d;
    logic                uses_rs2_d;
    logic                use_imm_d;

    assign opcode = insn_i[6:0];
    assign funct3 = insn_i[14:12];
    assign funct7 = insn_i[31:25];

    always_comb begin
        op_d       = helios_pkg::ALU_ADD;
        imm_d      = {{20{insn_i[31]}}, insn_i[31:20]};
        legal_d    = 1'b0;
        uses_rs1_d = 1'b0;
        uses_rs2_d = 1'b0;
        use_imm_d  = 1'b1;
        case (opcode)
            7'b0110011, 7'b0010011: begin
                uses_rs1_d = 1'b1;
                legal_d    = 1'b1;
                if (opcode[5]) begin
                    uses_rs2_d = 1'b1;
                    use_imm_d  = 1'b0;
                end
                case (funct3)
                    3'b000: begin
                        op_d = (opcode[5] && funct7[5]) ? helios_pkg::ALU_SUB
                                                        : helios_pkg::ALU_ADD;
                    end
                    3'b001: op_d = helios_pkg::ALU_SLL;
                    3'b010: op_d = helios_pkg::ALU_SLT;
                    3'b011: op_d = helios_pkg::ALU_SLTU;
                    3'b100: op_d = helios_pkg::ALU_XOR;
                    3'b101: op_d = funct7[5] ? helios_pkg::ALU_SRA : helios_pkg::ALU_SRL;
                    3'b110: op_d = helios_pkg::ALU_OR;
                    default: op_d = helios_pkg::ALU_AND;
                endcase
                // funct7 only matters for register ops and shifts
                if (opcode[5] || funct3 == 3'b001 || funct3 == 3'b101) begin
                    if (funct7 == 7'b0100000) begin
                        legal_d = (funct3 == 3'b101) || (opcode[5] && funct3 == 3'b000);
                    end else if (funct7 != 7'b0000000) begin
                        legal_d = 1'b0;
                    end
                end
            end
            7'b0110111: begin
                op_d    = helios_pkg::ALU_LUI;
                imm_d   = {insn_i[31:12], 12'b0};
                legal_d = 1'b1;
            end
            default: ;
        endcase
        // illegal becomes add of zero with no write
        if (!legal_d) begin
            op_d       = helios_pkg::ALU_ADD;
            imm_d      = '0;
            uses_rs1_d = 1'b0;
            uses_rs2_d = 1'b0;
            use_imm_d  = 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            dp_o.valid <= 1'b0;
        end else if (!stall_i) begin
            dp_o.valid <= insn_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            dp_o.rd       <= insn_i[11:7];
            dp_o.wr_reg   <= legal_d && (insn_i[11:7] != 5'd0);
            dp_o.rs1      <= insn_i[19:15];
            dp_o.rs2      <= insn_i[24:20];
            dp_o.uses_rs1 <= uses_rs1_d;
            dp_o.uses_rs2 <= uses_rs2_d;
            dp_o.use_imm  <= use_imm_d;
            dp_o.imm      <= imm_d;
            dp_o.alu_op   <= op_d;
        end
    end

endmodule

// ==== rtl/rename_unit.sv ====
`timescale 1ns/1ps

module rename_unit #(
    parameter int RRF_NUM = 8
) (
    input  logic                       clk_i,
    input  logic                       rst_i,
    dispatch_if.dst                    dp_i,
    input  logic                       rs_full_i,
    input  logic                       wb_valid_i,
    input  logic [$clog2(RRF_NUM)-1:0] wb_tag_i,
    input  helios_pkg::data_t          wb_data_i,
    input  logic                       com_valid_i,
    input  logic [$clog2(RRF_NUM)-1:0] com_tag_i,
    input  logic                       com_we_i,
    input  helios_pkg::reg_sel_t       com_rd_i,
    output logic                       stall_o,
    output helios_pkg::data_t          src1_o,
    output logic                       rdy1_o,
    output helios_pkg::data_t          src2_o,
    output logic                       rdy2_o,
    output logic [$clog2(RRF_NUM)-1:0] dst_tag_o,
    output helios_pkg::data_t          com_data_o
);

    localparam int TAG_W = $clog2(RRF_NUM);

    helios_pkg::data_t arf_q [32];
    logic [31:0]       busy_q;
    logic [TAG_W-1:0]  tag_q [32];
    helios_pkg::data_t rrf_data_q [RRF_NUM];
    logic [RRF_NUM-1:0] rrf_valid_q;
    logic [TAG_W-1:0]  tail_q;
    logic [TAG_W:0]    free_q;
    logic              alloc;

    // returns {ready, value}; value holds the tag while not ready
    function automatic logic [helios_pkg::XLEN:0] lookup(input helios_pkg::reg_sel_t rs,
                                                         input logic used);
        logic [TAG_W-1:0] t;
        t = tag_q[rs];
        if (!used) begin
            lookup = {1'b1, helios_pkg::data_t'(0)};
        end else if (!busy_q[rs]) begin
            lookup = {1'b1, arf_q[rs]};
        end else if (rrf_valid_q[t]) begin
            lookup = {1'b1, rrf_data_q[t]};
        end else if (wb_valid_i && wb_tag_i == t) begin
            lookup = {1'b1, wb_data_i};
        end else begin
            lookup = {1'b0, helios_pkg::data_t'(t)};
        end
    endfunction

    assign stall_o    = (free_q == '0) || rs_full_i;
    assign alloc      = dp_i.valid && !stall_o;
    assign dst_tag_o  = tail_q;
    assign com_data_o = rrf_data_q[com_tag_i];

    always_comb begin
        {rdy1_o, src1_o} = lookup(dp_i.rs1, dp_i.uses_rs1);
        {rdy2_o, src2_o} = lookup(dp_i.rs2, dp_i.uses_rs2 && !dp_i.use_imm);
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            busy_q      <= '0;
            rrf_valid_q <= '0;
            tail_q      <= '0;
            free_q      <= (TAG_W+1)'(RRF_NUM);
            for (int i = 0; i < 32; i++) begin
                arf_q[i] <= '0;
            end
        end else begin
            if (com_valid_i && com_we_i) begin
                arf_q[com_rd_i] <= com_data_o;
                // a younger writer keeps the register busy
                if (tag_q[com_rd_i] == com_tag_i) begin
                    busy_q[com_rd_i] <= 1'b0;
                end
            end
            if (alloc && dp_i.wr_reg) begin
                busy_q[dp_i.rd] <= 1'b1;
            end
            if (wb_valid_i) begin
                rrf_valid_q[wb_tag_i] <= 1'b1;
            end
            if (alloc) begin
                rrf_valid_q[tail_q] <= 1'b0;
                tail_q              <= tail_q + 1'b1;
            end
            case ({alloc, com_valid_i})
                2'b10:   free_q <= free_q - 1'b1;
                2'b01:   free_q <= free_q + 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (alloc && dp_i.wr_reg) begin
            tag_q[dp_i.rd] <= tail_q;
        end
        if (wb_valid_i) begin
            rrf_data_q[wb_tag_i] <= wb_data_i;
        end
    end

endmodule

// ==== rtl/alu_rs.sv ====
`timescale 1ns/1ps

module alu_rs #(
    parameter int RS_NUM  = 4,
    parameter int RRF_NUM = 8
) (
    input  logic                       clk_i,
    input  logic                       rst_i,
    dispatch_if.dst                    dp_i,
    input  logic                       stall_i,
    input  helios_pkg::data_t          src1_i,
    input  logic                       rdy1_i,
    input  helios_pkg::data_t          src2_i,
    input  logic                       rdy2_i,
    input  logic [$clog2(RRF_NUM)-1:0] dst_tag_i,
    input  logic                       wb_valid_i,
    input  logic [$clog2(RRF_NUM)-1:0] wb_tag_i,
    input  helios_pkg::data_t          wb_data_i,
    output logic                       rs_full_o,
    issue_if.src                       iss_o
);

    localparam int TAG_W = $clog2(RRF_NUM);
    localparam int IDX_W = (RS_NUM > 1) ? $clog2(RS_NUM) : 1;

    logic [RS_NUM-1:0]   busy_q;
    logic [RS_NUM-1:0]   rdya_q;
    logic [RS_NUM-1:0]   rdyb_q;
    helios_pkg::alu_op_t op_q [RS_NUM];
    helios_pkg::data_t   opa_q [RS_NUM];
    helios_pkg::data_t   opb_q [RS_NUM];
    logic [TAG_W-1:0]    taga_q [RS_NUM];
    logic [TAG_W-1:0]    tagb_q [RS_NUM];
    logic [TAG_W-1:0]    dst_q [RS_NUM];
    logic [IDX_W-1:0]    free_idx;
    logic [IDX_W-1:0]    iss_idx;
    logic                iss_hit;
    logic                write;

    assign rs_full_o = &busy_q;
    assign write     = dp_i.valid && !stall_i;

    // lowest free slot and lowest ready slot
    always_comb begin
        free_idx = '0;
        iss_idx  = '0;
        iss_hit  = 1'b0;
        for (int i = RS_NUM - 1; i >= 0; i--) begin
            if (!busy_q[i]) begin
                free_idx = IDX_W'(i);
            end
            if (busy_q[i] && rdya_q[i] && rdyb_q[i]) begin
                iss_idx = IDX_W'(i);
                iss_hit = 1'b1;
            end
        end
    end

    assign iss_o.valid  = iss_hit;
    assign iss_o.alu_op = op_q[iss_idx];
    assign iss_o.op_a   = opa_q[iss_idx];
    assign iss_o.op_b   = opb_q[iss_idx];
    assign iss_o.tag    = dst_q[iss_idx];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            busy_q <= '0;
        end else begin
            if (iss_hit) begin
                busy_q[iss_idx] <= 1'b0;
            end
            if (write) begin
                busy_q[free_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        // wakeup
        for (int i = 0; i < RS_NUM; i++) begin
            if (wb_valid_i && busy_q[i] && !rdya_q[i] && taga_q[i] == wb_tag_i) begin
                opa_q[i]  <= wb_data_i;
                rdya_q[i] <= 1'b1;
            end
            if (wb_valid_i && busy_q[i] && !rdyb_q[i] && tagb_q[i] == wb_tag_i) begin
                opb_q[i]  <= wb_data_i;
                rdyb_q[i] <= 1'b1;
            end
        end
        if (write) begin
            op_q[free_idx]   <= dp_i.alu_op;
            opa_q[free_idx]  <= src1_i;
            rdya_q[free_idx] <= rdy1_i;
            taga_q[free_idx] <= src1_i[TAG_W-1:0];
            opb_q[free_idx]  <= dp_i.use_imm ? dp_i.imm : src2_i;
            rdyb_q[free_idx] <= rdy2_i;
            tagb_q[free_idx] <= src2_i[TAG_W-1:0];
            dst_q[free_idx]  <= dst_tag_i;
        end
    end

endmodule

// ==== rtl/alu_exec.sv ====
`timescale 1ns/1ps

module alu_exec #(
    parameter int RRF_NUM = 8
) (
    input  logic                       clk_i,
    input  logic                       rst_i,
    issue_if.dst                       iss_i,
    output logic                       wb_valid_o,
    output logic [$clog2(RRF_NUM)-1:0] wb_tag_o,
    output helios_pkg::data_t          wb_data_o
);

    helios_pkg::data_t a;
    helios_pkg::data_t b;
    helios_pkg::data_t res;
    logic [4:0]        shamt;

    assign a     = iss_i.op_a;
    assign b     = iss_i.op_b;
    assign shamt = b[4:0];

    always_comb begin
        case (iss_i.alu_op)
            helios_pkg::ALU_SUB:  res = a - b;
            helios_pkg::ALU_AND:  res = a & b;
            helios_pkg::ALU_OR:   res = a | b;
            helios_pkg::ALU_XOR:  res = a ^ b;
            helios_pkg::ALU_SLL:  res = a << shamt;
            helios_pkg::ALU_SRL:  res = a >> shamt;
            helios_pkg::ALU_SRA:  res = helios_pkg::data_t'($signed(a) >>> shamt);
            helios_pkg::ALU_SLT:  res = helios_pkg::data_t'($signed(a) < $signed(b));
            helios_pkg::ALU_SLTU: res = helios_pkg::data_t'(a < b);
            helios_pkg::ALU_LUI:  res = b;
            default:              res = a + b;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wb_valid_o <= 1'b0;
        end else begin
            wb_valid_o <= iss_i.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        wb_tag_o  <= iss_i.tag;
        wb_data_o <= res;
    end

endmodule

// ==== rtl/reorder_buffer.sv ====
`timescale 1ns/1ps

module reorder_buffer #(
    parameter int RRF_NUM = 8
) (
    input  logic                       clk_i,
    input  logic                       rst_i,
    dispatch_if.dst                    dp_i,
    input  logic                       stall_i,
    input  logic                       wb_valid_i,
    input  logic [$clog2(RRF_NUM)-1:0] wb_tag_i,
    output logic                       com_valid_o,
    output logic [$clog2(RRF_NUM)-1:0] com_tag_o,
    output logic                       com_we_o,
    output helios_pkg::reg_sel_t       com_rd_o
);

    localparam int TAG_W = $clog2(RRF_NUM);

    logic [RRF_NUM-1:0]   used_q;
    logic [RRF_NUM-1:0]   done_q;
    logic [RRF_NUM-1:0]   we_q;
    helios_pkg::reg_sel_t rd_q [RRF_NUM];
    logic [TAG_W-1:0]     head_q;
    logic [TAG_W-1:0]     tail_q;
    logic                 alloc;

    // same allocation order as the rename tail
    assign alloc       = dp_i.valid && !stall_i;
    assign com_valid_o = used_q[head_q] && done_q[head_q];
    assign com_tag_o   = head_q;
    assign com_we_o    = com_valid_o && we_q[head_q];
    assign com_rd_o    = rd_q[head_q];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            used_q <= '0;
            done_q <= '0;
            head_q <= '0;
            tail_q <= '0;
        end else begin
            if (com_valid_o) begin
                used_q[head_q] <= 1'b0;
                head_q         <= head_q + 1'b1;
            end
            if (wb_valid_i) begin
                done_q[wb_tag_i] <= 1'b1;
            end
            if (alloc) begin
                used_q[tail_q] <= 1'b1;
                done_q[tail_q] <= 1'b0;
                tail_q         <= tail_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (alloc) begin
            rd_q[tail_q] <= dp_i.rd;
            we_q[tail_q] <= dp_i.wr_reg;
        end
    end

endmodule

// ==== rtl/helios_core.sv ====
`timescale 1ns/1ps

module helios_core #(
    parameter int RRF_NUM = 8,
    parameter int RS_NUM  = 4
) (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  helios_pkg::insn_t    idata_i,
    output helios_pkg::addr_t    iaddr_o,
    output logic                 commit_valid_o,
    output logic                 commit_we_o,
    output helios_pkg::reg_sel_t commit_rd_o,
    output helios_pkg::data_t    commit_data_o
);

    localparam int TAG_W = $clog2(RRF_NUM);

    // fetch to decode
    helios_pkg::insn_t insn;
    logic              insn_valid;
    logic              stall;

    // rename to station
    helios_pkg::data_t src1;
    logic              rdy1;
    helios_pkg::data_t src2;
    logic              rdy2;
    logic [TAG_W-1:0]  dst_tag;
    logic              rs_full;

    // writeback and commit
    logic              wb_valid;
    logic [TAG_W-1:0]  wb_tag;
    helios_pkg::data_t wb_data;
    logic [TAG_W-1:0]  com_tag;

    dispatch_if dp_bus ();
    issue_if #(.RRF_NUM(RRF_NUM)) iss_bus ();

    fetch_unit u_fetch (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .idata_i     (idata_i),
        .stall_i     (stall),
        .iaddr_o     (iaddr_o),
        .insn_o      (insn),
        .insn_valid_o(insn_valid)
    );

    decode_unit u_decode (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .insn_i      (insn),
        .insn_valid_i(insn_valid),
        .stall_i     (stall),
        .dp_o        (dp_bus.src)
    );

    rename_unit #(.RRF_NUM(RRF_NUM)) u_rename (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .dp_i       (dp_bus.dst),
        .rs_full_i  (rs_full),
        .wb_valid_i (wb_valid),
        .wb_tag_i   (wb_tag),
        .wb_data_i  (wb_data),
        .com_valid_i(commit_valid_o),
        .com_tag_i  (com_tag),
        .com_we_i   (commit_we_o),
        .com_rd_i   (commit_rd_o),
        .stall_o    (stall),
        .src1_o     (src1),
        .rdy1_o     (rdy1),
        .src2_o     (src2),
        .rdy2_o     (rdy2),
        .dst_tag_o  (dst_tag),
        .com_data_o (commit_data_o)
    );

    alu_rs #(.RS_NUM(RS_NUM), .RRF_NUM(RRF_NUM)) u_alu_rs (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .dp_i      (dp_bus.dst),
        .stall_i   (stall),
        .src1_i    (src1),
        .rdy1_i    (rdy1),
        .src2_i    (src2),
        .rdy2_i    (rdy2),
        .dst_tag_i (dst_tag),
        .wb_valid_i(wb_valid),
        .wb_tag_i  (wb_tag),
        .wb_data_i (wb_data),
        .rs_full_o (rs_full),
        .iss_o     (iss_bus.src)
    );

    alu_exec #(.RRF_NUM(RRF_NUM)) u_alu_exec (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .iss_i     (iss_bus.dst),
        .wb_valid_o(wb_valid),
        .wb_tag_o  (wb_tag),
        .wb_data_o (wb_data)
    );

    reorder_buffer #(.RRF_NUM(RRF_NUM)) u_rob (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .dp_i       (dp_bus.dst),
        .stall_i    (stall),
        .wb_valid_i (wb_valid),
        .wb_tag_i   (wb_tag),
        .com_valid_o(commit_valid_o),
        .com_tag_o  (com_tag),
        .com_we_o   (commit_we_o),
        .com_rd_o   (commit_rd_o)
    );

endmodule

// ==== testbench/tb_checker.sv ====
`timescale 1ns/1ps

module tb_checker #(
    parameter int PROG_LEN = 64
) (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  helios_pkg::addr_t    iaddr_i,
    input  logic                 commit_valid_i,
    input  logic                 commit_we_i,
    input  helios_pkg::reg_sel_t commit_rd_i,
    input  helios_pkg::data_t    commit_data_i,
    input  helios_pkg::insn_t    prog_i [PROG_LEN],
    output logic                 done_o,
    output int                   err_cnt_o,
    output int                   commits_o
);

    localparam int         RESET_LIMIT    = 100;
    localparam int         COMMIT_TIMEOUT = 200;
    localparam logic [6:0] OPC_OP         = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM     = 7'b0010011;
    localparam logic [6:0] OPC_LUI        = 7'b0110111;

    helios_pkg::data_t ref_regs [32];
    helios_pkg::addr_t prev_addr;
    logic              prev_valid;
    int                hold_cnt;
    int                cyc;
    int                wait_cyc;

    // {writes, value} from the rv32i rules and the reference registers
    function automatic logic [32:0] expected_commit(input helios_pkg::insn_t insn);
        logic [6:0]         opcode;
        logic [2:0]         f3;
        logic [6:0]         f7;
        logic               legal;
        helios_pkg::data_t  a;
        helios_pkg::data_t  b;
        helios_pkg::data_t  r;
        logic signed [31:0] sra_val;
        opcode  = insn[6:0];
        f3      = insn[14:12];
        f7      = insn[31:25];
        a       = ref_regs[insn[19:15]];
        b       = (opcode == OPC_OP) ? ref_regs[insn[24:20]] : {{20{insn[31]}}, insn[31:20]};
        sra_val = $signed(a) >>> b[4:0];
        legal   = 1'b0;
        r       = '0;
        if (opcode == OPC_LUI) begin
            legal = 1'b1;
            r     = {insn[31:12], 12'b0};
        end else if (opcode == OPC_OP || opcode == OPC_OP_IMM) begin
            legal = 1'b1;
            if (opcode == OPC_OP && f7 != 7'h00 && !(f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5))) begin
                legal = 1'b0;
            end
            if (opcode == OPC_OP_IMM && f3 == 3'd1 && f7 != 7'h00) begin
                legal = 1'b0;
            end
            if (opcode == OPC_OP_IMM && f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20) begin
                legal = 1'b0;
            end
            case (f3)
                3'd0:    r = (opcode == OPC_OP && f7[5]) ? a - b : a + b;
                3'd1:    r = a << b[4:0];
                3'd2:    r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                3'd3:    r = (a < b) ? 32'd1 : 32'd0;
                3'd4:    r = a ^ b;
                3'd5:    r = f7[5] ? sra_val : a >> b[4:0];
                3'd6:    r = a | b;
                default: r = a & b;
            endcase
        end
        return {legal && (insn[11:7] != 5'd0), r};
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
        err_cnt_o++;
    endtask

    task automatic check_commit(input int idx);
        helios_pkg::insn_t insn;
        logic [32:0]       exp;
        insn = prog_i[idx];
        exp  = expected_commit(insn);
        if (commit_we_i !== exp[32]) begin
            report_mismatch("commit_we_o", 32'(exp[32]), 32'(commit_we_i));
        end else if (exp[32]) begin
            if (commit_rd_i !== insn[11:7]) begin
                report_mismatch("commit_rd_o", 32'(insn[11:7]), 32'(commit_rd_i));
            end
            if (commit_data_i !== exp[31:0]) begin
                report_mismatch("commit_data_o", exp[31:0], commit_data_i);
            end
            ref_regs[insn[11:7]] = exp[31:0];
        end
        commits_o++;
    endtask

    // fetch address either holds or steps by one word
    task automatic track_fetch();
        if (prev_valid) begin
            if (iaddr_i === prev_addr) begin
                hold_cnt++;
            end else if (iaddr_i !== prev_addr + 32'd4) begin
                report_mismatch("iaddr_o", prev_addr + 32'd4, iaddr_i);
            end
        end
        prev_addr  = iaddr_i;
        prev_valid = 1'b1;
    endtask

    initial begin
        done_o     = 1'b0;
        err_cnt_o  = 0;
        commits_o  = 0;
        hold_cnt   = 0;
        prev_valid = 1'b0;
        prev_addr  = '0;
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        // outputs are defined from the first reset edge on
        cyc = 0;
        while (rst_i !== 1'b0 && cyc < RESET_LIMIT) begin
            @(posedge clk_i);
            if (rst_i === 1'b1 && cyc > 0) begin
                if (iaddr_i !== 32'd0) begin
                    report_mismatch("iaddr_o", 32'd0, iaddr_i);
                end
                if (commit_valid_i !== 1'b0) begin
                    report_mismatch("commit_valid_o", 32'd0, 32'(commit_valid_i));
                end
            end
            cyc++;
        end
        if (rst_i !== 1'b0) begin
            $display("reset was not released within %0d cycles", RESET_LIMIT);
            err_cnt_o++;
        end else begin
            wait_cyc = 0;
            while (commits_o < PROG_LEN && wait_cyc < COMMIT_TIMEOUT) begin
                @(posedge clk_i);
                track_fetch();
                if (commit_valid_i === 1'b1) begin
                    check_commit(commits_o);
                    wait_cyc = 0;
                end else begin
                    wait_cyc++;
                end
            end
            if (commits_o < PROG_LEN) begin
                $display("instruction %0d did not commit within %0d cycles",
                         commits_o, COMMIT_TIMEOUT);
                err_cnt_o++;
            end
            if (hold_cnt == 0) begin
                $display("fetch never held its address under back-pressure");
                err_cnt_o++;
            end
        end
        done_o = 1'b1;
    end

endmodule

// ==== testbench/tb_top.sv ====
`timescale 1ns/1ps

module tb_top;

    localparam int                PROG_LEN  = 64;
    localparam int                RUN_LIMIT = 5000;
    localparam logic [31:0]       RAND_SEED = 32'h031e_f8fc;
    localparam helios_pkg::insn_t NOP       = 32'h0000_0013;

    logic                 clk_i;
    logic                 rst_i;
    helios_pkg::insn_t    idata_i;
    helios_pkg::addr_t    iaddr_o;
    logic                 commit_valid_o;
    logic                 commit_we_o;
    helios_pkg::reg_sel_t commit_rd_o;
    helios_pkg::data_t    commit_data_o;

    helios_pkg::insn_t program_mem [PROG_LEN];
    helios_pkg::addr_t word_idx;
    logic              chk_done;
    int                chk_errors;
    int                chk_commits;
    int                cyc;

    function automatic helios_pkg::insn_t encode_reg_op(input logic [6:0] f7,
        input logic [4:0] rs2, input logic [4:0] rs1, input logic [2:0] f3,
        input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic helios_pkg::insn_t encode_imm_op(input logic [11:0] imm,
        input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic helios_pkg::insn_t encode_lui(input logic [19:0] imm,
        input logic [4:0] rd);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic helios_pkg::insn_t random_alu_insn();
        int                kind;
        logic [2:0]        f3;
        logic [6:0]        f7;
        logic [4:0]        rd;
        logic [4:0]        rs1;
        logic [4:0]        rs2;
        logic [11:0]       imm;
        helios_pkg::insn_t insn;
        kind = int'($urandom % 3);
        f3   = 3'($urandom);
        rd   = 5'($urandom % 16);
        rs1  = 5'($urandom % 16);
        rs2  = 5'($urandom % 16);
        f7   = ((f3 == 3'd0 || f3 == 3'd5) && ($urandom % 2) == 1) ? 7'h20 : 7'h00;
        imm  = 12'($urandom);
        // shift immediates keep a legal upper field
        if (f3 == 3'd1 || f3 == 3'd5) begin
            imm = {f7, rs2};
        end
        if (kind == 0) begin
            insn = encode_reg_op(f7, rs2, rs1, f3, rd);
        end else if (kind == 1) begin
            insn = encode_imm_op(imm, rs1, f3, rd);
        end else begin
            insn = encode_lui(20'($urandom), rd);
        end
        return insn;
    endfunction

    task automatic build_program();
        // dependent adds through x1..x7
        program_mem[0]  = encode_imm_op(12'd5, 5'd0, 3'd0, 5'd1);
        program_mem[1]  = encode_imm_op(12'hffd, 5'd1, 3'd0, 5'd2);
        program_mem[2]  = encode_reg_op(7'h00, 5'd2, 5'd1, 3'd0, 5'd3);
        program_mem[3]  = encode_reg_op(7'h00, 5'd3, 5'd3, 3'd0, 5'd3);
        program_mem[4]  = encode_reg_op(7'h20, 5'd1, 5'd3, 3'd0, 5'd4);
        program_mem[5]  = encode_reg_op(7'h00, 5'd3, 5'd4, 3'd0, 5'd5);
        program_mem[6]  = encode_lui(20'habcde, 5'd6);
        program_mem[7]  = encode_reg_op(7'h00, 5'd5, 5'd6, 3'd0, 5'd7);
        // x0 writes, illegal words, reads of x0
        program_mem[8]  = encode_imm_op(12'd9, 5'd1, 3'd0, 5'd0);
        program_mem[9]  = encode_reg_op(7'h00, 5'd1, 5'd0, 3'd0, 5'd10);
        program_mem[10] = 32'hffff_ffff;
        program_mem[11] = encode_reg_op(7'h01, 5'd2, 5'd1, 3'd0, 5'd11);
        program_mem[12] = encode_imm_op({7'h20, 5'd3}, 5'd1, 3'd1, 5'd12);
        program_mem[13] = encode_reg_op(7'h00, 5'd0, 5'd0, 3'd6, 5'd13);
        // long chain on x8 to fill the station and the rob
        for (int i = 14; i < 34; i++) begin
            program_mem[i] = encode_imm_op(12'd3, 5'd8, 3'd0, 5'd8);
        end
        for (int i = 34; i < PROG_LEN; i++) begin
            program_mem[i] = random_alu_insn();
        end
    endtask

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // instruction memory answers on the falling edge
    always @(negedge clk_i) begin
        word_idx = iaddr_o >> 2;
        if (word_idx < helios_pkg::addr_t'(PROG_LEN)) begin
            idata_i = program_mem[int'(word_idx)];
        end else begin
            idata_i = NOP;
        end
    end

    helios_core dut_i (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .idata_i       (idata_i),
        .iaddr_o       (iaddr_o),
        .commit_valid_o(commit_valid_o),
        .commit_we_o   (commit_we_o),
        .commit_rd_o   (commit_rd_o),
        .commit_data_o (commit_data_o)
    );

    tb_checker #(.PROG_LEN(PROG_LEN)) u_checker (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .iaddr_i       (iaddr_o),
        .commit_valid_i(commit_valid_o),
        .commit_we_i   (commit_we_o),
        .commit_rd_i   (commit_rd_o),
        .commit_data_i (commit_data_o),
        .prog_i        (program_mem),
        .done_o        (chk_done),
        .err_cnt_o     (chk_errors),
        .commits_o     (chk_commits)
    );

    initial begin
        rst_i   = 1'b1;
        idata_i = NOP;
        void'($urandom(RAND_SEED));
        build_program();
        repeat (10) @(negedge clk_i);
        rst_i = 1'b0;
        cyc = 0;
        while (chk_done !== 1'b1 && cyc < RUN_LIMIT) begin
            @(posedge clk_i);
            cyc++;
        end
        if (chk_done !== 1'b1) begin
            $display("checker did not finish within %0d cycles", RUN_LIMIT);
        end
        $display("errors %0d, commits checked %0d of %0d", chk_errors, chk_commits, PROG_LEN);
        if (chk_done === 1'b1 && chk_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== files.f ====
rtl/helios_pkg.sv
rtl/core_ifs.sv
rtl/fetch_unit.sv
rtl/decode_unit.sv
rtl/rename_unit.sv
rtl/alu_rs.sv
rtl/alu_exec.sv
rtl/reorder_buffer.sv
rtl/helios_core.sv
testbench/tb_checker.sv
testbench/tb_top.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -f files.f --top-module tb_top -o tb_sim
./obj_dir/tb_sim | tee sim.log

if grep -q "sim failed" sim.log; then
    exit 1
fi
exit 0
